// ==== cs_pkg.sv ====
package cs_pkg;

  // Router geometry
  localparam int NUM_PORTS = 5;
  // Circuit payload width
  localparam int DATA_W = 80;

  // Port numbering, fixed by the mesh wiring
  typedef enum logic [2:0] {
    PORT_SOUTH = 3'd0,
    PORT_EAST  = 3'd1,
    PORT_NORTH = 3'd2,
    PORT_WEST  = 3'd3,
    PORT_LOCAL = 3'd4
  } port_e;

  // Port number, values above PORT_LOCAL mean no port
  typedef logic [2:0] port_idx_t;

  // One bit per port
  typedef logic [NUM_PORTS-1:0] port_mask_t;

  // Circuit payload
  typedef logic [DATA_W-1:0] flit_data_t;

  // Forward half of a link
  // tail and stream are transition signalled, data is stable while an event is open
  typedef struct packed {
    logic       tail;
    logic       stream;
    flit_data_t data;
  } link_fwd_t;

  // Setup request, valid for one cycle
  typedef struct packed {
    logic      valid;
    port_idx_t src;
    port_idx_t dst;
  } circuit_req_t;

  // Open event of an input link
  typedef struct packed {
    logic       pending;
    logic       is_tail;
    flit_data_t data;
  } port_event_t;

endpackage

// ==== circuit_table.sv ====
`timescale 1ns/10ps

module circuit_table (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cs_pkg::circuit_req_t setup_req,
  input  cs_pkg::port_mask_t   tail_done,
  output logic                 setup_grant,
  output logic                 setup_deny,
  output cs_pkg::port_idx_t    out_owner [cs_pkg::NUM_PORTS],
  output cs_pkg::port_mask_t   out_valid,
  output cs_pkg::port_idx_t    in_dst [cs_pkg::NUM_PORTS],
  output cs_pkg::port_mask_t   in_valid
);
  import cs_pkg::*;

  // Owner input of each output
  port_idx_t  owner_q [NUM_PORTS];
  // Destination output of each input
  port_idx_t  dst_q [NUM_PORTS];
  port_mask_t out_valid_q;
  port_mask_t in_valid_q;

  port_mask_t src_bit;
  port_mask_t dst_bit;
  port_mask_t freed_in;
  port_mask_t freed_out;
  logic       req_in_range;
  logic       req_ok;
  logic       req_take;

  // One-hot request masks, zero for an index past the last port
  assign src_bit = port_mask_t'(1) << setup_req.src;
  assign dst_bit = port_mask_t'(1) << setup_req.dst;

  assign req_in_range = (setup_req.src <= port_idx_t'(PORT_LOCAL)) &&
                        (setup_req.dst <= port_idx_t'(PORT_LOCAL));

  // Grant rule
  // no U-turn, source idle, destination free
  assign req_ok = req_in_range &&
                  (setup_req.src != setup_req.dst) &&
                  ((src_bit & in_valid_q) == '0) &&
                  ((dst_bit & out_valid_q) == '0);

  assign req_take = setup_req.valid && req_ok;

  // Circuits whose tail completes this cycle
  assign freed_in = tail_done & in_valid_q;

  always_comb begin
    freed_out = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (freed_in[i]) begin
        freed_out = freed_out | (port_mask_t'(1) << dst_q[i]);
      end
    end
  end

  // Valid bits and answer pulses
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_valid_q  <= '0;
      out_valid_q <= '0;
      setup_grant <= 1'b0;
      setup_deny  <= 1'b0;
    end else begin
      // Both sides of a circuit set and clear together
      in_valid_q  <= (in_valid_q & ~freed_in) | (req_take ? src_bit : '0);
      out_valid_q <= (out_valid_q & ~freed_out) | (req_take ? dst_bit : '0);
      setup_grant <= req_take;
      setup_deny  <= setup_req.valid && !req_ok;
    end
  end

  // Index registers, written on grant
  always_ff @(posedge clk) begin
    if (req_take) begin
      dst_q[setup_req.src]   <= setup_req.dst;
      owner_q[setup_req.dst] <= setup_req.src;
    end
  end

  assign out_valid = out_valid_q;
  assign in_valid  = in_valid_q;

  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      out_owner[i] = owner_q[i];
      // Idle input sees an index past the last port
      in_dst[i]    = in_valid_q[i] ? dst_q[i] : port_idx_t'(NUM_PORTS);
    end
  end

endmodule

// ==== input_port.sv ====
`timescale 1ns/10ps

module input_port (
  input  logic                clk,
  input  logic                rst_n,
  input  cs_pkg::link_fwd_t   link,
  input  cs_pkg::port_idx_t   dst,
  input  cs_pkg::port_mask_t  done,
  output cs_pkg::port_event_t event_out,
  output logic                ack,
  output logic                tail_done
);
  import cs_pkg::*;

  // Acknowledged phases of the two event wires
  logic tail_ph;
  logic stream_ph;

  logic tail_diff;
  logic stream_diff;
  logic sel_done;
  logic acked;

  // Level differs from phase means an open event
  assign tail_diff   = link.tail ^ tail_ph;
  assign stream_diff = link.stream ^ stream_ph;

  assign event_out.pending = tail_diff | stream_diff;
  assign event_out.is_tail = tail_diff;
  assign event_out.data    = link.data;

  // Done bit of the routed output, none when dst is out of range
  always_comb begin
    sel_done = 1'b0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (dst == port_idx_t'(p)) begin
        sel_done = done[p];
      end
    end
  end

  assign acked = sel_done && event_out.pending;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tail_ph   <= 1'b0;
      stream_ph <= 1'b0;
    end else if (acked) begin
      // Close whichever wire is open
      if (tail_diff) tail_ph <= link.tail;
      else stream_ph <= link.stream;
    end
  end

  // One upstream toggle per closed event
  assign ack       = tail_ph ^ stream_ph;
  assign tail_done = acked && tail_diff;

endmodule

// ==== output_port.sv ====
`timescale 1ns/10ps

module output_port (
  input  logic                clk,
  input  logic                rst_n,
  input  cs_pkg::port_event_t events [cs_pkg::NUM_PORTS],
  input  cs_pkg::port_idx_t   owner,
  input  logic                owner_valid,
  input  logic                ack_in,
  output cs_pkg::link_fwd_t   link,
  output logic                done
);
  import cs_pkg::*;

  // Crossbar column for this output
  port_event_t sel;
  // Downstream levels and data
  link_fwd_t   link_q;
  // Event sent, ack outstanding
  logic        busy;
  // Last ack level seen from downstream
  logic        ack_ph;
  logic        fire;

  assign sel = events[owner];

  // Accept a new event only with a circuit and no ack outstanding
  assign fire = !busy && owner_valid && sel.pending;

  // Fresh downstream toggle closes the open event
  assign done = busy && (ack_in != ack_ph);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy   <= 1'b0;
      ack_ph <= 1'b0;
      link_q <= '0;
    end else begin
      ack_ph <= ack_in;
      if (done) begin
        busy <= 1'b0;
      end
      if (fire) begin
        busy <= 1'b1;
        // Pass the transition on the same wire
        if (sel.is_tail) begin
          link_q.tail <= ~link_q.tail;
        end else begin
          link_q.stream <= ~link_q.stream;
        end
        // Data settles with the toggle
        link_q.data <= sel.data;
      end
    end
  end

  assign link = link_q;

endmodule

// ==== cs_switch.sv ====
`timescale 1ns/10ps

module cs_switch (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cs_pkg::circuit_req_t setup_req,
  input  cs_pkg::link_fwd_t    link_in [cs_pkg::NUM_PORTS],
  input  cs_pkg::port_mask_t   ack_in,
  output cs_pkg::link_fwd_t    link_out [cs_pkg::NUM_PORTS],
  output cs_pkg::port_mask_t   ack_out,
  output logic                 setup_grant,
  output logic                 setup_deny
);
  import cs_pkg::*;

  // Open events, one per input
  port_event_t events [NUM_PORTS];
  // Per output, ack seen this cycle
  port_mask_t  done;
  // Per input, tail closed this cycle
  port_mask_t  tail_done;

  // Circuit table view
  port_idx_t   out_owner [NUM_PORTS];
  port_mask_t  out_valid;
  port_idx_t   in_dst [NUM_PORTS];

  // Input side validity is already folded into in_dst
  circuit_table u_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .setup_req  (setup_req),
    .tail_done  (tail_done),
    .setup_grant(setup_grant),
    .setup_deny (setup_deny),
    .out_owner  (out_owner),
    .out_valid  (out_valid),
    .in_dst     (in_dst),
    .in_valid   ()
  );

  // South, east, north, west, local
  for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
    input_port u_in (
      .clk      (clk),
      .rst_n    (rst_n),
      .link     (link_in[i]),
      .dst      (in_dst[i]),
      .done     (done),
      .event_out(events[i]),
      .ack      (ack_out[i]),
      .tail_done(tail_done[i])
    );
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    output_port u_out (
      .clk        (clk),
      .rst_n      (rst_n),
      .events     (events),
      .owner      (out_owner[o]),
      .owner_valid(out_valid[o]),
      .ack_in     (ack_in[o]),
      .link       (link_out[o]),
      .done       (done[o])
    );
  end

endmodule

// ==== tb_cs_switch.sv ====
`timescale 1ns/10ps

module tb_cs_switch;
  import cs_pkg::*;

  logic         clk;
  logic         rst_n;
  circuit_req_t setup_req;
  link_fwd_t    link_in [NUM_PORTS];
  port_mask_t   ack_in;
  link_fwd_t    link_out [NUM_PORTS];
  port_mask_t   ack_out;
  logic         setup_grant;
  logic         setup_deny;

  // Circuit table of the model
  logic         m_in_valid [NUM_PORTS];
  port_idx_t    m_dst [NUM_PORTS];
  logic         m_out_valid [NUM_PORTS];
  port_idx_t    m_owner [NUM_PORTS];
  // Acknowledged upstream phases and ack wires
  logic         m_tail_ph [NUM_PORTS];
  logic         m_stream_ph [NUM_PORTS];
  logic         m_ack [NUM_PORTS];
  // Output side, busy until downstream acks
  logic         m_busy [NUM_PORTS];
  logic         m_ack_ph [NUM_PORTS];
  link_fwd_t    m_link [NUM_PORTS];
  logic         m_grant;
  logic         m_deny;

  logic [31:0]  lfsr_q;
  int           errors;
  flit_data_t   d0;
  flit_data_t   d1;

  cs_switch uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .setup_req  (setup_req),
    .link_in    (link_in),
    .ack_in     (ack_in),
    .link_out   (link_out),
    .ack_out    (ack_out),
    .setup_grant(setup_grant),
    .setup_deny (setup_deny)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  // One LFSR step per bit
  function automatic flit_data_t rand_bits(int n);
    flit_data_t r;
    r = '0;
    for (int b = 0; b < n; b++) begin
      r = {r[DATA_W-2:0], lfsr_bit()};
    end
    return r;
  endfunction

  task automatic check(string name, flit_data_t got, flit_data_t exp);
    if (got !== exp) begin
      errors++;
      $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
      $display("TB FAILED");
      $fatal(1, "value mismatch on %s", name);
    end
  endtask

  task automatic model_reset();
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_in_valid[p]  = 1'b0;
      m_dst[p]       = '0;
      m_out_valid[p] = 1'b0;
      m_owner[p]     = '0;
      m_tail_ph[p]   = 1'b0;
      m_stream_ph[p] = 1'b0;
      m_ack[p]       = 1'b0;
      m_busy[p]      = 1'b0;
      m_ack_ph[p]    = 1'b0;
      m_link[p]      = '0;
    end
    m_grant = 1'b0;
    m_deny  = 1'b0;
  endtask

  // Model of one rising edge with the inputs now driven
  task automatic model_step();
    logic      done [NUM_PORTS];
    logic      fire [NUM_PORTS];
    logic      open_ev [NUM_PORTS];
    logic      close_ev [NUM_PORTS];
    logic      is_tail [NUM_PORTS];
    logic      req_ok;
    port_idx_t src;
    port_idx_t dst;
    src = setup_req.src;
    dst = setup_req.dst;
    // Grant rule, judged on the table before this edge
    req_ok = (src < 3'd5) && (dst < 3'd5) && (src != dst) &&
             !m_in_valid[src] && !m_out_valid[dst];
    for (int p = 0; p < NUM_PORTS; p++) begin
      is_tail[p] = link_in[p].tail ^ m_tail_ph[p];
      open_ev[p] = is_tail[p] | (link_in[p].stream ^ m_stream_ph[p]);
      // Fresh downstream toggle closes the outstanding event
      done[p]    = m_busy[p] && (ack_in[p] != m_ack_ph[p]);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      close_ev[p] = m_in_valid[p] && open_ev[p] && done[m_dst[p]];
      fire[p]     = !m_busy[p] && m_out_valid[p] && open_ev[m_owner[p]];
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      m_ack_ph[p] = ack_in[p];
      if (done[p]) begin
        m_busy[p] = 1'b0;
      end
      if (fire[p]) begin
        m_busy[p] = 1'b1;
        if (is_tail[m_owner[p]]) begin
          m_link[p].tail = ~m_link[p].tail;
        end else begin
          m_link[p].stream = ~m_link[p].stream;
        end
        m_link[p].data = link_in[m_owner[p]].data;
      end
      // Upstream ack, tail also ends the circuit
      if (close_ev[p]) begin
        m_ack[p] = ~m_ack[p];
        if (is_tail[p]) begin
          m_tail_ph[p]          = link_in[p].tail;
          m_in_valid[p]         = 1'b0;
          m_out_valid[m_dst[p]] = 1'b0;
        end else begin
          m_stream_ph[p] = link_in[p].stream;
        end
      end
    end
    m_grant = setup_req.valid && req_ok;
    m_deny  = setup_req.valid && !req_ok;
    if (m_grant) begin
      m_in_valid[src]  = 1'b1;
      m_dst[src]       = dst;
      m_out_valid[dst] = 1'b1;
      m_owner[dst]     = src;
    end
  endtask

  task automatic compare_outputs();
    check("setup_grant", flit_data_t'(setup_grant), flit_data_t'(m_grant));
    check("setup_deny", flit_data_t'(setup_deny), flit_data_t'(m_deny));
    for (int p = 0; p < NUM_PORTS; p++) begin
      check($sformatf("ack_out[%0d]", p), flit_data_t'(ack_out[p]), flit_data_t'(m_ack[p]));
      check($sformatf("link_out[%0d].tail", p), flit_data_t'(link_out[p].tail),
            flit_data_t'(m_link[p].tail));
      check($sformatf("link_out[%0d].stream", p), flit_data_t'(link_out[p].stream),
            flit_data_t'(m_link[p].stream));
      check($sformatf("link_out[%0d].data", p), link_out[p].data, m_link[p].data);
    end
  endtask

  // One clock, checked at the falling edge
  task automatic next_cycle();
    model_step();
    @(negedge clk);
    compare_outputs();
    setup_req = '0;
  endtask

  task automatic send_event(int p, logic tail, flit_data_t data);
    link_in[p].data = data;
    if (tail) begin
      link_in[p].tail = ~link_in[p].tail;
    end else begin
      link_in[p].stream = ~link_in[p].stream;
    end
  endtask

  task automatic request_expect(port_idx_t src, port_idx_t dst, logic grant);
    setup_req.valid = 1'b1;
    setup_req.src   = src;
    setup_req.dst   = dst;
    next_cycle();
    check("setup_grant", flit_data_t'(setup_grant), flit_data_t'(grant));
    check("setup_deny", flit_data_t'(setup_deny), flit_data_t'(!grant));
  endtask

  // Downstream acks after a random delay
  task automatic ack_random();
    flit_data_t r;
    for (int o = 0; o < NUM_PORTS; o++) begin
      if ((m_link[o].tail ^ m_link[o].stream) != ack_in[o]) begin
        r = rand_bits(2);
        if (r[1:0] == 2'd0) begin
          ack_in[o] = ~ack_in[o];
        end
      end
    end
  endtask

  task automatic drive_random();
    flit_data_t r;
    flit_data_t kind;
    r = rand_bits(2);
    if (r[1:0] == 2'd0) begin
      // Port numbers past local get denied
      r = rand_bits(6);
      setup_req.valid = 1'b1;
      setup_req.src   = r[5:3];
      setup_req.dst   = r[2:0];
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      // Sender idle once all its events are acked
      if ((link_in[p].tail ^ link_in[p].stream) == m_ack[p]) begin
        r = rand_bits(2);
        if (r[1:0] != 2'd0) begin
          kind = rand_bits(2);
          send_event(p, kind[1:0] == 2'd0, rand_bits(DATA_W));
        end
      end
    end
    ack_random();
  endtask

  function automatic logic any_busy();
    logic b;
    b = 1'b0;
    for (int o = 0; o < NUM_PORTS; o++) begin
      b = b | m_busy[o];
    end
    return b;
  endfunction

  task automatic drain_outputs();
    int waited;
    waited = 0;
    while (any_busy() && waited < 200) begin
      ack_random();
      next_cycle();
      waited++;
    end
    if (any_busy()) begin
      $display("Timeout: downstream acks did not drain within 200 cycles");
      $display("TB FAILED");
      $fatal(1, "drain timeout");
    end
  endtask

  initial begin
    #100000;
    $display("Timeout: simulation did not finish in time");
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    lfsr_q    = 32'h24498cd6;
    errors    = 0;
    rst_n     = 1'b0;
    setup_req = '0;
    ack_in    = '0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      link_in[p] = '0;
    end
    model_reset();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    compare_outputs();

    // Stream on south, no circuit yet
    d0 = rand_bits(DATA_W);
    send_event(0, 1'b0, d0);
    repeat (20) begin
      next_cycle();
      check("ack_out", flit_data_t'(ack_out), '0);
      for (int p = 0; p < NUM_PORTS; p++) begin
        check("link_out tail", flit_data_t'(link_out[p].tail), '0);
        check("link_out stream", flit_data_t'(link_out[p].stream), '0);
      end
    end

    // Setups, waiting south event leaves on north
    request_expect(3'd0, 3'd2, 1'b1);
    next_cycle();
    check("link_out[2].stream", flit_data_t'(link_out[2].stream), flit_data_t'(1'b1));
    check("link_out[2].data", link_out[2].data, d0);
    request_expect(3'd2, 3'd2, 1'b0);
    request_expect(3'd1, 3'd2, 1'b0);
    request_expect(3'd0, 3'd4, 1'b0);
    request_expect(3'd5, 3'd1, 1'b0);
    request_expect(3'd1, 3'd3, 1'b1);

    // East to west stream, one cycle through
    d1 = rand_bits(DATA_W);
    send_event(1, 1'b0, d1);
    next_cycle();
    check("link_out[3].stream", flit_data_t'(link_out[3].stream), flit_data_t'(1'b1));
    check("link_out[3].data", link_out[3].data, d1);
    ack_in[3] = 1'b1;
    next_cycle();
    check("ack_out[1]", flit_data_t'(ack_out[1]), flit_data_t'(1'b1));

    // Ack return, circuit kept after stream
    ack_in[2] = 1'b1;
    next_cycle();
    check("ack_out[0]", flit_data_t'(ack_out[0]), flit_data_t'(1'b1));
    d0 = rand_bits(DATA_W);
    send_event(0, 1'b0, d0);
    next_cycle();
    check("link_out[2].stream", flit_data_t'(link_out[2].stream), '0);
    check("link_out[2].data", link_out[2].data, d0);
    ack_in[2] = 1'b0;
    next_cycle();
    check("ack_out[0]", flit_data_t'(ack_out[0]), '0);

    // Tail ends the south circuit
    send_event(0, 1'b1, rand_bits(DATA_W));
    next_cycle();
    check("link_out[2].tail", flit_data_t'(link_out[2].tail), flit_data_t'(1'b1));
    ack_in[2] = 1'b1;
    next_cycle();
    check("ack_out[0]", flit_data_t'(ack_out[0]), flit_data_t'(1'b1));
    d0 = rand_bits(DATA_W);
    send_event(0, 1'b0, d0);
    repeat (5) begin
      next_cycle();
      check("link_out[2].stream", flit_data_t'(link_out[2].stream), '0);
      check("ack_out[0]", flit_data_t'(ack_out[0]), flit_data_t'(1'b1));
    end
    request_expect(3'd4, 3'd2, 1'b1);
    request_expect(3'd0, 3'd1, 1'b1);
    next_cycle();
    check("link_out[1].stream", flit_data_t'(link_out[1].stream), flit_data_t'(1'b1));
    check("link_out[1].data", link_out[1].data, d0);

    // Random traffic against the model
    repeat (3000) begin
      drive_random();
      next_cycle();
    end
    drain_outputs();

    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
cs_pkg.sv
circuit_table.sv
input_port.sv
output_port.sv
cs_switch.sv
tb_cs_switch.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cs_switch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps --top-module tb_cs_switch -f sim.f

status=0
./obj_dir/Vtb_cs_switch > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"
